/* logic/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] EXC_VECTOR_BASE = 32'h0000_0080;
    localparam logic [XLEN-1:0] RESET_PC        = 32'h0000_0000;

    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FUNCT_ADD = 6'h20,
        FUNCT_SUB = 6'h22,
        FUNCT_AND = 6'h24
    } funct_e;

    typedef enum logic [3:0] {
        FETCH, FETCH_WAIT, DECODE, EXEC_R, EXEC_I, ADDR_CALC, MEM_READ,
        MEM_WRITE, WB_ALU, WB_IMM, WB_LOAD, JUMP, EXC_VECTOR, EXC_ENTER
    } state_e;

    typedef enum logic [1:0] {PASS_A, ADD, SUB, AND} alu_op_e;
    typedef enum logic [0:0] {OPCODE, OVERFLOW} exc_cause_e;
    typedef enum logic [1:0] {PC_INC, PC_JUMP, PC_MEM} pc_src_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_FOUR, SRC_B_IMM} alu_src_b_e;
    typedef enum logic [1:0] {ADDR_PC, ADDR_ALU, ADDR_VECTOR} mem_addr_src_e;

    typedef struct packed {
        logic          pc_write;
        pc_src_e       pc_src;
        logic          epc_write;
        logic          ir_write;
        logic          ab_write;
        logic          alu_out_write;
        logic          mdr_write;
        logic          reg_write;
        logic          reg_dst;       // 0 rd, 1 rt
        logic          reg_src;       // 0 ALU result, 1 MDR
        logic          alu_src_a;     // 0 PC, 1 A
        alu_src_b_e    alu_src_b;
        alu_op_e       alu_op;
        mem_addr_src_e mem_addr_src;
        exc_cause_e    exc_cause;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic            write;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            done;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic              awvalid;
        logic [XLEN-1:0]   awaddr;
        logic              wvalid;
        logic [XLEN-1:0]   wdata;
        logic [XLEN/8-1:0] wstrb;
        logic              bready;
        logic              arvalid;
        logic [XLEN-1:0]   araddr;
        logic              rready;
    } axi_m2s_t;

    typedef struct packed {
        logic            awready;
        logic            wready;
        logic            bvalid;
        logic [1:0]      bresp;
        logic            arready;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
        logic [1:0]      rresp;
    } axi_s2m_t;

endpackage

/* logic/mips_control.sv */
`timescale 1ns/1ps

module mips_control (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::opcode_e  opcode,
    input  mips_pkg::funct_e   funct,
    input  logic               overflow,
    input  mips_pkg::mem_rsp_t mem_rsp,
    output mips_pkg::ctrl_t    ctrl,
    output logic               mem_req_valid,
    output logic               mem_req_write
);
    import mips_pkg::*;

    state_e  state;
    state_e  next_state;
    logic    opcode_legal;
    alu_op_e r_op;

    always_comb begin
        if (opcode == R_TYPE) begin
            opcode_legal = funct inside {FUNCT_ADD, FUNCT_SUB, FUNCT_AND};
        end else begin
            opcode_legal = opcode inside {ADDI, ADDIU, LW, SW, J};
        end
        case (funct)
            FUNCT_SUB: r_op = SUB;
            FUNCT_AND: r_op = AND;
            default:   r_op = ADD;
        endcase
    end

    always_comb begin
        ctrl          = '0;
        mem_req_valid = 1'b0;
        mem_req_write = 1'b0;
        next_state    = state;
        case (state)
            FETCH: begin
                mem_req_valid = 1'b1;
                next_state    = FETCH_WAIT;
            end
            FETCH_WAIT: begin
                // ALU computes PC + 4 while the fetch is in flight
                mem_req_valid  = 1'b1;
                ctrl.alu_src_b = SRC_B_FOUR;
                ctrl.alu_op    = ADD;
                if (mem_rsp.done) begin
                    ctrl.ir_write = 1'b1;
                    ctrl.pc_write = 1'b1;
                    next_state    = DECODE;
                end
            end
            DECODE: begin
                ctrl.ab_write = 1'b1;
                if (!opcode_legal) begin
                    next_state = EXC_VECTOR;
                end else begin
                    case (opcode)
                        R_TYPE:      next_state = EXEC_R;
                        ADDI, ADDIU: next_state = EXEC_I;
                        LW, SW:      next_state = ADDR_CALC;
                        default:     next_state = JUMP;
                    endcase
                end
            end
            EXEC_R, WB_ALU: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = SRC_B_REG;
                ctrl.alu_op    = r_op;
                if (state == EXEC_R) begin
                    ctrl.alu_out_write = 1'b1;
                    next_state         = WB_ALU;
                end else if (overflow) begin
                    next_state = EXC_VECTOR;
                end else begin
                    ctrl.reg_write = 1'b1;
                    next_state     = FETCH;
                end
            end
            EXEC_I, WB_IMM, ADDR_CALC: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_src_b = SRC_B_IMM;
                ctrl.alu_op    = ADD;
                if (state == EXEC_I) begin
                    ctrl.alu_out_write = 1'b1;
                    next_state         = WB_IMM;
                end else if (state == ADDR_CALC) begin
                    ctrl.alu_out_write = 1'b1;
                    next_state         = (opcode == LW) ? MEM_READ : MEM_WRITE;
                end else if (overflow && opcode == ADDI) begin
                    next_state = EXC_VECTOR;
                end else begin
                    ctrl.reg_write = 1'b1;
                    ctrl.reg_dst   = 1'b1;
                    next_state     = FETCH;
                end
            end
            MEM_READ: begin
                mem_req_valid     = 1'b1;
                ctrl.mem_addr_src = ADDR_ALU;
                ctrl.mdr_write    = mem_rsp.done;
                if (mem_rsp.done) begin
                    next_state = WB_LOAD;
                end
            end
            WB_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_src   = 1'b1;
                next_state     = FETCH;
            end
            MEM_WRITE: begin
                mem_req_valid     = 1'b1;
                mem_req_write     = 1'b1;
                ctrl.mem_addr_src = ADDR_ALU;
                if (mem_rsp.done) begin
                    next_state = FETCH;
                end
            end
            JUMP: begin
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = PC_JUMP;
                next_state    = FETCH;
            end
            EXC_VECTOR: begin
                // A legal instruction can only get here through overflow
                mem_req_valid     = 1'b1;
                ctrl.mem_addr_src = ADDR_VECTOR;
                ctrl.exc_cause    = opcode_legal ? OVERFLOW : OPCODE;
                ctrl.mdr_write    = mem_rsp.done;
                if (mem_rsp.done) begin
                    next_state = EXC_ENTER;
                end
            end
            EXC_ENTER: begin
                ctrl.epc_write = 1'b1;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_src    = PC_MEM;
                next_state     = FETCH;
            end
            default: next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    // Request stays up until the port reports completion
    req_held_until_done: assert property (@(posedge clk) disable iff (reset)
        $fell(mem_req_valid) |-> $past(mem_rsp.done));

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_pkg::ctrl_t             ctrl,
    input  logic [mips_pkg::XLEN-1:0]   instr,
    input  logic [mips_pkg::XLEN-1:0]   wdata_alu,
    input  logic [mips_pkg::XLEN-1:0]   wdata_mem,
    output logic [mips_pkg::XLEN-1:0]   rdata_a,
    output logic [mips_pkg::XLEN-1:0]   rdata_b
);
    import mips_pkg::*;

    logic [XLEN-1:0]       regs [0:2**REG_ADDR_W-1];
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;

    assign waddr = ctrl.reg_dst ? instr[20:16] : instr[15:11];
    assign wdata = ctrl.reg_src ? wdata_mem : wdata_alu;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[instr[25:21]];
    assign rdata_b = regs[instr[20:16]];

    reg_zero_stays_zero: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  mips_pkg::ctrl_t           ctrl,
    input  logic [mips_pkg::XLEN-1:0] pc,
    input  logic [mips_pkg::XLEN-1:0] a,
    input  logic [mips_pkg::XLEN-1:0] b,
    input  logic [mips_pkg::XLEN-1:0] imm,
    output logic [mips_pkg::XLEN-1:0] result,
    output logic                      overflow
);
    import mips_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    always_comb begin
        op_a = ctrl.alu_src_a ? a : pc;
        case (ctrl.alu_src_b)
            SRC_B_FOUR: op_b = XLEN'(4);
            SRC_B_IMM:  op_b = imm;
            default:    op_b = b;
        endcase
    end

    always_comb begin
        overflow = 1'b0;
        case (ctrl.alu_op)
            ADD: begin
                result   = op_a + op_b;
                overflow = (op_a[XLEN-1] == op_b[XLEN-1]) &&
                           (result[XLEN-1] != op_a[XLEN-1]);
            end
            SUB: begin
                result   = op_a - op_b;
                overflow = (op_a[XLEN-1] != op_b[XLEN-1]) &&
                           (result[XLEN-1] != op_a[XLEN-1]);
            end
            AND:     result = op_a & op_b;
            default: result = op_a;
        endcase
    end

endmodule

/* logic/operand_regs.sv */
`timescale 1ns/1ps

module operand_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  mips_pkg::ctrl_t           ctrl,
    input  logic [mips_pkg::XLEN-1:0] mem_rdata,
    input  logic [mips_pkg::XLEN-1:0] rdata_a,
    input  logic [mips_pkg::XLEN-1:0] rdata_b,
    input  logic [mips_pkg::XLEN-1:0] alu_result,
    output logic [mips_pkg::XLEN-1:0] instr,
    output mips_pkg::opcode_e         opcode,
    output mips_pkg::funct_e          funct,
    output logic [mips_pkg::XLEN-1:0] imm,
    output logic [mips_pkg::XLEN-1:0] a,
    output logic [mips_pkg::XLEN-1:0] b,
    output logic [mips_pkg::XLEN-1:0] alu_out,
    output logic [mips_pkg::XLEN-1:0] mdr
);
    import mips_pkg::*;

    // Instruction register
    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (ctrl.ir_write) begin
            instr <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ab_write) begin
            a <= rdata_a;
            b <= rdata_b;
        end
        if (ctrl.alu_out_write) begin
            alu_out <= alu_result;
        end
        if (ctrl.mdr_write) begin
            mdr <= mem_rdata;
        end
    end

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign imm    = {{(XLEN-16){instr[15]}}, instr[15:0]};

endmodule

/* logic/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  mips_pkg::ctrl_t           ctrl,
    input  logic [mips_pkg::XLEN-1:0] alu_result,
    input  logic [mips_pkg::XLEN-1:0] instr,
    input  logic [mips_pkg::XLEN-1:0] mem_rdata,
    output logic [mips_pkg::XLEN-1:0] pc,
    output logic [mips_pkg::XLEN-1:0] epc
);
    import mips_pkg::*;

    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] next_pc;

    // PC already points past the jump here
    assign jump_target = {pc[XLEN-1:28], instr[25:0], 2'b00};

    always_comb begin
        case (ctrl.pc_src)
            PC_JUMP: next_pc = jump_target;
            PC_MEM:  next_pc = mem_rdata;
            default: next_pc = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (ctrl.pc_write) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.epc_write) begin
            epc <= pc - XLEN'(4);
        end
    end

endmodule

/* logic/axi_mem_port.sv */
`timescale 1ns/1ps

module axi_mem_port (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::mem_req_t req,
    output mips_pkg::mem_rsp_t rsp,
    output mips_pkg::axi_m2s_t axi_m,
    input  mips_pkg::axi_s2m_t axi_s
);
    import mips_pkg::*;

    typedef enum logic [1:0] {PORT_IDLE, PORT_ADDR, PORT_RESP} port_state_e;

    port_state_e     state;
    logic            is_write;
    logic            awvalid;
    logic            wvalid;
    logic            arvalid;
    logic            aw_left;
    logic            w_left;
    logic            ar_left;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;

    // Each channel drops its valid on its own handshake
    assign aw_left = awvalid && !axi_s.awready;
    assign w_left  = wvalid && !axi_s.wready;
    assign ar_left = arvalid && !axi_s.arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= PORT_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (req.valid) begin
                        awvalid <= req.write;
                        wvalid  <= req.write;
                        arvalid <= !req.write;
                        state   <= PORT_ADDR;
                    end
                end
                PORT_ADDR: begin
                    awvalid <= aw_left;
                    wvalid  <= w_left;
                    arvalid <= ar_left;
                    if (!aw_left && !w_left && !ar_left) begin
                        state <= PORT_RESP;
                    end
                end
                default: begin
                    if (rsp.done) begin
                        state <= PORT_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && req.valid) begin
            is_write <= req.write;
            addr     <= req.addr;
            wdata    <= req.wdata;
        end
    end

    always_comb begin
        axi_m.awvalid = awvalid;
        axi_m.awaddr  = addr;
        axi_m.wvalid  = wvalid;
        axi_m.wdata   = wdata;
        axi_m.wstrb   = '1;
        axi_m.bready  = (state == PORT_RESP) && is_write;
        axi_m.arvalid = arvalid;
        axi_m.araddr  = addr;
        axi_m.rready  = (state == PORT_RESP) && !is_write;
    end

    assign rsp.done  = (axi_m.bready && axi_s.bvalid) || (axi_m.rready && axi_s.rvalid);
    assign rsp.rdata = axi_s.rdata;

    awaddr_stable: assert property (@(posedge clk) disable iff (reset)
        axi_m.awvalid && !axi_s.awready |=> axi_m.awvalid && $stable(axi_m.awaddr));

endmodule

/* logic/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic               clk,
    input  logic               reset,
    output mips_pkg::axi_m2s_t axi_m,
    input  mips_pkg::axi_s2m_t axi_s
);
    import mips_pkg::*;

    ctrl_t           ctrl;
    opcode_e         opcode;
    funct_e          funct;
    mem_req_t        mem_req;
    mem_rsp_t        mem_rsp;
    logic            overflow;
    logic            mem_valid;
    logic            mem_write;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] mdr;

    always_comb begin
        mem_req.valid = mem_valid;
        mem_req.write = mem_write;
        mem_req.wdata = b;
        case (ctrl.mem_addr_src)
            ADDR_ALU:    mem_req.addr = alu_out;
            ADDR_VECTOR: mem_req.addr = EXC_VECTOR_BASE + (XLEN'(ctrl.exc_cause) << 2);
            default:     mem_req.addr = pc;
        endcase
    end

    mips_control u_control (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .overflow(overflow), .mem_rsp(mem_rsp), .ctrl(ctrl),
        .mem_req_valid(mem_valid), .mem_req_write(mem_write)
    );

    register_file u_register_file (
        .clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr),
        .wdata_alu(alu_out), .wdata_mem(mdr), .rdata_a(rdata_a), .rdata_b(rdata_b)
    );

    alu u_alu (
        .ctrl(ctrl), .pc(pc), .a(a), .b(b), .imm(imm),
        .result(alu_result), .overflow(overflow)
    );

    operand_regs u_operand_regs (
        .clk(clk), .reset(reset), .ctrl(ctrl), .mem_rdata(mem_rsp.rdata),
        .rdata_a(rdata_a), .rdata_b(rdata_b), .alu_result(alu_result),
        .instr(instr), .opcode(opcode), .funct(funct), .imm(imm),
        .a(a), .b(b), .alu_out(alu_out), .mdr(mdr)
    );

    // Handler address comes from MDR, latched when the vector read completed
    pc_unit u_pc_unit (
        .clk(clk), .reset(reset), .ctrl(ctrl), .alu_result(alu_result),
        .instr(instr), .mem_rdata(mdr), .pc(pc), .epc()
    );

    axi_mem_port u_axi_mem_port (
        .clk(clk), .reset(reset), .req(mem_req), .rsp(mem_rsp),
        .axi_m(axi_m), .axi_s(axi_s)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

endmodule

/* testbench/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    localparam int GOLDEN_WORDS     = 512;
    localparam int MEM_AW           = 8;
    localparam int MEM_WORDS        = 2**MEM_AW;
    localparam int RESET_CYCLES     = 16;
    localparam int CYCLES_PER_EVENT = 40;
    localparam int WAIT_FACTOR      = 4;

    localparam logic [31:0] KIND_MEM   = 32'd1;
    localparam logic [31:0] KIND_WRITE = 32'd2;
    localparam logic [31:0] KIND_READ  = 32'd3;

    logic        clk;
    logic        reset;
    axi_m2s_t    axi_m;
    axi_s2m_t    axi_s;
    logic [31:0] golden [0:GOLDEN_WORDS-1];
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] exp_write_addr [$];
    logic [31:0] exp_write_data [$];
    logic [31:0] exp_read_addr [$];
    logic [31:0] lfsr;
    int          mismatch_count;
    int          other_errors;
    int          reads_seen;
    int          writes_seen;
    int          cycle_count;
    int          cycle_limit;

    tb_clock u_tb_clock (.clk(clk));

    mips_core u_mips_core (
        .clk(clk), .reset(reset), .axi_m(axi_m), .axi_s(axi_s)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic take_random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // 0 to 3 wait states
    function automatic int pick_delay();
        logic hi;
        logic lo;
        hi = take_random_bit();
        lo = take_random_bit();
        return int'({hi, lo});
    endfunction

    function automatic void report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        other_errors++;
    endfunction

    function automatic logic addr_in_range(input logic [31:0] addr);
        return addr < 32'(MEM_WORDS * 4) && addr[1:0] == 2'b00;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        assert (addr_in_range(addr)) else begin
            report_failure($sformatf("read from %h is outside the memory model", addr));
        end
        return mem[addr[MEM_AW+1:2]];
    endfunction

    function automatic void write_word(input logic [31:0] addr, input logic [31:0] data);
        assert (addr_in_range(addr)) else begin
            report_failure($sformatf("write to %h is outside the memory model", addr));
        end
        mem[addr[MEM_AW+1:2]] = data;
    endfunction

    function automatic void check_read(input logic [31:0] addr);
        logic [31:0] expected;
        reads_seen++;
        if (exp_read_addr.size() != 0) begin
            expected = exp_read_addr.pop_front();
            assert (addr == expected) else begin
                $display("MISMATCH at %0t: read address %h, expected %h",
                         $time, addr, expected);
                mismatch_count++;
            end
        end
    endfunction

    function automatic void check_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] want_addr;
        logic [31:0] want_data;
        writes_seen++;
        assert (exp_write_addr.size() != 0) else begin
            report_failure($sformatf("store of %h to %h when no store was expected", data, addr));
        end
        if (exp_write_addr.size() != 0) begin
            want_addr = exp_write_addr.pop_front();
            want_data = exp_write_data.pop_front();
            assert (addr == want_addr && data == want_data) else begin
                $display("MISMATCH at %0t: store %h to %h, expected %h to %h",
                         $time, data, addr, want_data, want_addr);
                mismatch_count++;
            end
        end
    endfunction

    task automatic load_golden();
        int i;
        for (i = 0; i < GOLDEN_WORDS; i++) begin
            golden[i] = '0;
        end
        // Unwritten words hold the inverted byte address
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ~(32'(i) << 2);
        end
        $readmemh("testbench/program_golden.txt", golden);
        i = 0;
        while (i + 2 < GOLDEN_WORDS && golden[i] != '0) begin
            case (golden[i])
                KIND_MEM: write_word(golden[i+1], golden[i+2]);
                KIND_WRITE: begin
                    exp_write_addr.push_back(golden[i+1]);
                    exp_write_data.push_back(golden[i+2]);
                end
                KIND_READ: exp_read_addr.push_back(golden[i+1]);
                default: report_failure($sformatf("golden file has unknown kind %h", golden[i]));
            endcase
            i += 3;
        end
        assert (exp_read_addr.size() != 0) else begin
            report_failure("golden file gave no expected reads");
        end
    endtask

    task automatic serve_read();
        logic [31:0] addr;
        int          delay;
        addr  = axi_m.araddr;
        delay = pick_delay();
        repeat (delay) begin
            @(negedge clk);
        end
        assert (axi_m.arvalid && axi_m.araddr == addr) else begin
            report_failure("read address changed or withdrawn before it was accepted");
        end
        axi_s.arready = 1'b1;
        @(negedge clk);
        axi_s.arready = 1'b0;
        check_read(addr);
        delay = pick_delay();
        repeat (delay) begin
            @(negedge clk);
        end
        axi_s.rdata  = read_word(addr);
        axi_s.rresp  = 2'b00;
        axi_s.rvalid = 1'b1;
        while (!axi_m.rready) begin
            @(negedge clk);
        end
        @(negedge clk);
        axi_s.rvalid = 1'b0;
    endtask

    task automatic serve_write();
        logic [31:0] addr;
        logic [31:0] data;
        logic        aw_done;
        logic        w_done;
        int          aw_delay;
        int          w_delay;
        int          delay;
        aw_done  = 1'b0;
        w_done   = 1'b0;
        aw_delay = pick_delay();
        w_delay  = pick_delay();
        // Address and data channels are accepted independently
        while (!(aw_done && w_done)) begin
            axi_s.awready = !aw_done && axi_m.awvalid && aw_delay == 0;
            axi_s.wready  = !w_done && axi_m.wvalid && w_delay == 0;
            if (axi_s.awready) begin
                addr = axi_m.awaddr;
            end
            if (axi_s.wready) begin
                data = axi_m.wdata;
                assert (axi_m.wstrb == '1) else begin
                    report_failure("write strobes are not all ones");
                end
            end
            if (aw_delay > 0) begin
                aw_delay--;
            end
            if (w_delay > 0) begin
                w_delay--;
            end
            @(negedge clk);
            aw_done       = aw_done || axi_s.awready;
            w_done        = w_done || axi_s.wready;
            axi_s.awready = 1'b0;
            axi_s.wready  = 1'b0;
        end
        check_write(addr, data);
        write_word(addr, data);
        delay = pick_delay();
        repeat (delay) begin
            @(negedge clk);
        end
        axi_s.bresp  = 2'b00;
        axi_s.bvalid = 1'b1;
        while (!axi_m.bready) begin
            @(negedge clk);
        end
        @(negedge clk);
        axi_s.bvalid = 1'b0;
    endtask

    // AXI4-Lite slave, one access at a time
    initial begin
        axi_s = '0;
        forever begin
            @(negedge clk);
            if (!reset && axi_m.arvalid) begin
                serve_read();
            end else if (!reset && (axi_m.awvalid || axi_m.wvalid)) begin
                serve_write();
            end
        end
    end

    initial begin
        reset          = 1'b1;
        lfsr           = 32'h3b42;
        mismatch_count = 0;
        other_errors   = 0;
        reads_seen     = 0;
        writes_seen    = 0;
        cycle_count    = 0;
        load_golden();
        cycle_limit = CYCLES_PER_EVENT * WAIT_FACTOR *
                      (exp_read_addr.size() + exp_write_addr.size());
        repeat (RESET_CYCLES) begin
            @(negedge clk);
        end
        reset = 1'b0;
        while ((exp_read_addr.size() != 0 || exp_write_addr.size() != 0) &&
               cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        if (exp_read_addr.size() != 0 || exp_write_addr.size() != 0) begin
            report_failure($sformatf(
                "timed out after %0d cycles, %0d reads and %0d stores missing",
                cycle_count, exp_read_addr.size(), exp_write_addr.size()));
        end
        $display("Done in %0d cycles: %0d reads, %0d stores, %0d mismatches, %0d other errors",
                 cycle_count, reads_seen, writes_seen, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/program_golden.txt */
// Records of three hex words: kind addr data. Kind 1 preloads a memory word,
// kind 2 is an expected store and kind 3 an expected read (data 0). Stores and reads in bus order
1 00000000 20011234 // addi  $1, $0, 0x1234
1 00000004 2402fff0 // addiu $2, $0, -16
1 00000008 00221820 // add   $3, $1, $2
1 0000000c 00222022 // sub   $4, $1, $2
1 00000010 00222824 // and   $5, $1, $2
1 00000014 ac010200 // sw    $1, 0x200($0)
1 00000018 ac020204 // sw    $2, 0x204($0)
1 0000001c ac030208 // sw    $3, 0x208($0)
1 00000020 ac04020c // sw    $4, 0x20c($0)
1 00000024 ac050210 // sw    $5, 0x210($0)
1 00000028 8c060100 // lw    $6, 0x100($0)
1 0000002c ac060214 // sw    $6, 0x214($0)
1 00000030 08000010 // j     0x40
1 00000034 ac010218 // skipped by the jump
1 00000040 fc000000 // unknown opcode
1 00000044 ac01021c // skipped by the exception
1 00000060 20080055 // addi  $8, $0, 0x55
1 00000064 8c070104 // lw    $7, 0x104($0)
1 00000068 00e74020 // add   $8, $7, $7 overflows
1 0000006c ac080224 // skipped by the exception
1 00000070 ac080220 // sw    $8, 0x220($0)
1 00000074 0800001d // j     0x74
1 00000080 00000060 // handler for unknown opcode
1 00000084 00000070 // handler for overflow
1 00000100 cafef00d
1 00000104 7fffffff
2 00000200 00001234
2 00000204 fffffff0
2 00000208 00001224
2 0000020c 00001244
2 00000210 00001230
2 00000214 cafef00d
2 00000220 00000055
3 00000000 0  3 00000004 0  3 00000008 0  3 0000000c 0
3 00000010 0  3 00000014 0  3 00000018 0  3 0000001c 0
3 00000020 0  3 00000024 0  3 00000028 0  3 00000100 0
3 0000002c 0  3 00000030 0  3 00000040 0  3 00000080 0
3 00000060 0  3 00000064 0  3 00000104 0  3 00000068 0
3 00000084 0  3 00000070 0  3 00000074 0  3 00000074 0

/* all.f */
logic/mips_pkg.sv
logic/mips_control.sv
logic/register_file.sv
logic/alu.sv
logic/operand_regs.sv
logic/pc_unit.sv
logic/axi_mem_port.sv
logic/mips_core.sv
testbench/tb_clock.sv
testbench/tb_mips_core.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_mips_core and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mips_core -Mdir obj_dir
	./obj_dir/Vtb_mips_core | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
